/* src/vertex_pkg.sv */
// Shared widths, vector types and enums for the vertex job controller RTL and its testbench
`default_nettype none

package vertex_pkg;

	////////////////////////////////////////
	// Line geometry
	////////////////////////////////////////

	parameter int VERTEX_W      = 32;
	parameter int LINE_VERTICES = 8;
	parameter int LINE_W        = VERTEX_W * LINE_VERTICES;
	parameter int LINE_BYTES    = LINE_W / 8;

	////////////////////////////////////////
	// Vector types
	////////////////////////////////////////

	typedef logic [VERTEX_W-1:0] vertex_word_t;
	typedef logic [VERTEX_W-1:0] vertex_id_t;
	typedef logic [31:0]         addr_t;

	// Word 0 in the low bits
	typedef logic [LINE_W-1:0] line_t;

	// Wide enough to hold LINE_VERTICES itself, not just the last index
	typedef logic [$clog2(LINE_VERTICES+1)-1:0] line_index_t;

	typedef logic [39:0] edge_count_t;

	////////////////////////////////////////
	// Enums
	////////////////////////////////////////

	typedef enum logic {
		ARRAY_OUT_DEGREE,
		ARRAY_EDGES_IDX
	} array_sel_t;

	typedef enum logic [2:0] {
		FETCH_IDLE,
		ISSUE_OUT_DEGREE,
		ISSUE_EDGES_IDX,
		WAIT_LINES,
		SHIFT_VERTICES,
		NEXT_BLOCK
	} fetch_state_t;

endpackage

`default_nettype wire

/* src/vertex_fetch_fsm.sv */
// Block sequencer of the vertex job controller; issues reads, waits for lines, shifts vertices
`timescale 1ns/100ps
`default_nettype none

module vertex_fetch_fsm (
	input  logic                   clock,
	input  logic                   rstn,
	input  logic                   start,
	input  logic                   work_left,
	input  logic                   shift_last,
	input  logic                   lines_ready,
	input  logic                   room_for_line,
	output logic                   load,
	output logic                   block_advance,
	output logic                   shift_step,
	output logic                   lines_clear,
	output logic                   push,
	output logic                   rd_cmd_valid,
	output logic                   busy,
	output vertex_pkg::array_sel_t rd_cmd_array
);

	import vertex_pkg::*;

	fetch_state_t state;
	fetch_state_t next_state;

	////////////////////////////////////////
	// State register
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			state <= FETCH_IDLE;
		end else begin
			state <= next_state;
		end
	end

	////////////////////////////////////////
	// Next state and control pulses
	////////////////////////////////////////

	always_comb begin
		next_state    = state;
		load          = 1'b0;
		block_advance = 1'b0;
		shift_step    = 1'b0;
		lines_clear   = 1'b0;
		push          = 1'b0;

		case (state)
			FETCH_IDLE: begin
				if (start) begin
					load       = 1'b1;
					next_state = NEXT_BLOCK;
				end
			end
			// Decision point between blocks, also right after start
			NEXT_BLOCK: begin
				if (!work_left) begin
					next_state = FETCH_IDLE;
				end else if (room_for_line) begin
					next_state = ISSUE_OUT_DEGREE;
				end
			end
			ISSUE_OUT_DEGREE: begin
				next_state = ISSUE_EDGES_IDX;
			end
			ISSUE_EDGES_IDX: begin
				next_state = WAIT_LINES;
			end
			WAIT_LINES: begin
				// Lines may come back in either order
				if (lines_ready) begin
					next_state = SHIFT_VERTICES;
				end
			end
			SHIFT_VERTICES: begin
				push       = 1'b1;
				shift_step = 1'b1;
				if (shift_last) begin
					lines_clear   = 1'b1;
					block_advance = 1'b1;
					next_state    = NEXT_BLOCK;
				end
			end
			default: begin
				next_state = FETCH_IDLE;
			end
		endcase
	end

	////////////////////////////////////////
	// Command strobe and status
	////////////////////////////////////////

	assign rd_cmd_valid = (state == ISSUE_OUT_DEGREE) || (state == ISSUE_EDGES_IDX);

	// Out-degree tag is the default outside the issue states
	assign rd_cmd_array = (state == ISSUE_EDGES_IDX) ? ARRAY_EDGES_IDX : ARRAY_OUT_DEGREE;

	assign busy = (state != FETCH_IDLE);

endmodule

`default_nettype wire

/* src/vertex_block_counter.sv */
// Remaining-vertex, block offset, shift index and vertex id counters for the fetch sequencer
`timescale 1ns/100ps
`default_nettype none

module vertex_block_counter (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    load,
	input  logic                    block_advance,
	input  logic                    shift_step,
	input  vertex_pkg::vertex_id_t  num_vertices,
	output logic                    work_left,
	output logic                    shift_last,
	output vertex_pkg::line_index_t line_count,
	output vertex_pkg::line_index_t shift_index,
	output vertex_pkg::addr_t       block_offset,
	output vertex_pkg::vertex_id_t  vertex_id
);

	import vertex_pkg::*;

	vertex_id_t  remaining;
	line_index_t next_index;

	assign work_left  = (remaining != '0);
	assign line_count = (remaining >= vertex_id_t'(LINE_VERTICES)) ?
		line_index_t'(LINE_VERTICES) : line_index_t'(remaining);

	assign next_index = shift_index + 1'b1;
	assign shift_last = (next_index == line_count);

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			remaining    <= '0;
			block_offset <= '0;
			shift_index  <= '0;
			vertex_id    <= '0;
		end else if (load) begin
			remaining    <= num_vertices;
			block_offset <= '0;
			shift_index  <= '0;
			vertex_id    <= '0;
		end else begin
			if (shift_step) begin
				shift_index <= next_index;
				vertex_id   <= vertex_id + 1'b1;
			end
			// Block change wins over the last shift step
			if (block_advance) begin
				remaining    <= remaining - vertex_id_t'(line_count);
				block_offset <= block_offset + addr_t'(LINE_BYTES);
				shift_index  <= '0;
			end
		end
	end

endmodule

`default_nettype wire

/* src/array_line_buffer.sv */
// Holds the returned out-degree and edge-index lines and picks the word under the shift index
`timescale 1ns/100ps
`default_nettype none

module array_line_buffer (
	input  logic                    clock,
	input  logic                    rstn,
	input  logic                    rd_data_valid,
	input  logic                    lines_clear,
	input  vertex_pkg::array_sel_t  rd_data_array,
	input  vertex_pkg::line_t       rd_data_line,
	input  vertex_pkg::line_index_t shift_index,
	output logic                    lines_ready,
	output vertex_pkg::vertex_word_t out_degree_word,
	output vertex_pkg::vertex_word_t edges_idx_word
);

	import vertex_pkg::*;

	// One slot per array, indexed by the tag
	line_t      lines [2];
	logic [1:0] ready;

	always_ff @(posedge clock) begin
		if (rd_data_valid) begin
			lines[rd_data_array] <= rd_data_line;
		end
	end

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			ready <= '0;
		end else begin
			if (lines_clear) begin
				ready <= '0;
			end
			if (rd_data_valid) begin
				ready[rd_data_array] <= 1'b1;
			end
		end
	end

	assign lines_ready = &ready;

	////////////////////////////////////////
	// Word select
	////////////////////////////////////////

	assign out_degree_word = lines[ARRAY_OUT_DEGREE][shift_index*VERTEX_W +: VERTEX_W];
	assign edges_idx_word  = lines[ARRAY_EDGES_IDX][shift_index*VERTEX_W +: VERTEX_W];

endmodule

`default_nettype wire

/* src/vertex_job_queue.sv */
// Zero-degree filter, job FIFO with credit-gated output, and job statistics counters
`timescale 1ns/100ps
`default_nettype none

module vertex_job_queue #(
	parameter int JOB_DEPTH   = 16,
	parameter int JOB_CREDITS = 8
) (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     push,
	input  logic                     credit_return,
	input  vertex_pkg::vertex_id_t   vertex_id,
	input  vertex_pkg::vertex_word_t out_degree_word,
	input  vertex_pkg::vertex_word_t edges_idx_word,
	output logic                     room_for_line,
	output logic                     job_valid,
	output vertex_pkg::vertex_id_t   job_id,
	output vertex_pkg::vertex_word_t job_out_degree,
	output vertex_pkg::vertex_word_t job_edges_idx,
	output vertex_pkg::vertex_id_t   vertex_job_count,
	output vertex_pkg::vertex_id_t   filtered_count,
	output vertex_pkg::edge_count_t  edge_job_count
);

	import vertex_pkg::*;

	localparam int PTR_W    = (JOB_DEPTH > 1) ? $clog2(JOB_DEPTH) : 1;
	localparam int COUNT_W  = $clog2(JOB_DEPTH + 1);
	localparam int CREDIT_W = $clog2(JOB_CREDITS + 1);

	vertex_id_t   id_mem  [JOB_DEPTH];
	vertex_word_t deg_mem [JOB_DEPTH];
	vertex_word_t idx_mem [JOB_DEPTH];

	logic [PTR_W-1:0]    wr_ptr;
	logic [PTR_W-1:0]    rd_ptr;
	logic [COUNT_W-1:0]  fill;
	logic [CREDIT_W-1:0] credits;
	logic                keep;

	// Vertices with no outgoing edges never become jobs
	assign keep = push && (out_degree_word != '0);

	always_ff @(posedge clock) begin
		if (keep) begin
			id_mem[wr_ptr]  <= vertex_id;
			deg_mem[wr_ptr] <= out_degree_word;
			idx_mem[wr_ptr] <= edges_idx_word;
		end
	end

	////////////////////////////////////////
	// FIFO pointers, fill level and credits
	////////////////////////////////////////

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			fill    <= '0;
			credits <= CREDIT_W'(JOB_CREDITS);
		end else begin
			if (keep) begin
				wr_ptr <= (wr_ptr == PTR_W'(JOB_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (job_valid) begin
				rd_ptr <= (rd_ptr == PTR_W'(JOB_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (keep && !job_valid) begin
				fill <= fill + 1'b1;
			end else if (!keep && job_valid) begin
				fill <= fill - 1'b1;
			end
			if (credit_return && !job_valid) begin
				credits <= credits + 1'b1;
			end else if (!credit_return && job_valid) begin
				credits <= credits - 1'b1;
			end
		end
	end

	assign room_for_line  = (fill <= COUNT_W'(JOB_DEPTH - LINE_VERTICES));
	assign job_valid      = (fill != '0) && (credits != '0);
	assign job_id         = id_mem[rd_ptr];
	assign job_out_degree = deg_mem[rd_ptr];
	assign job_edges_idx  = idx_mem[rd_ptr];

	// Totals run from reset and span every start
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			vertex_job_count <= '0;
			filtered_count   <= '0;
			edge_job_count   <= '0;
		end else begin
			if (push && !keep) begin
				filtered_count <= filtered_count + 1'b1;
			end
			if (job_valid) begin
				vertex_job_count <= vertex_job_count + 1'b1;
				edge_job_count   <= edge_job_count + edge_count_t'(job_out_degree);
			end
		end
	end

endmodule

`default_nettype wire

/* src/vertex_job_control.sv */
// Top level of the vertex job controller; base registers, command address and submodule wiring
`timescale 1ns/100ps
`default_nettype none

module vertex_job_control #(
	parameter int JOB_DEPTH   = 16,
	parameter int JOB_CREDITS = 8
) (
	input  logic                     clock,
	input  logic                     rstn,
	input  logic                     start,
	input  vertex_pkg::vertex_id_t   num_vertices,
	input  vertex_pkg::addr_t        out_degree_base,
	input  vertex_pkg::addr_t        edges_idx_base,
	input  logic                     rd_data_valid,
	input  vertex_pkg::array_sel_t   rd_data_array,
	input  vertex_pkg::line_t        rd_data_line,
	input  logic                     credit_return,
	output logic                     rd_cmd_valid,
	output vertex_pkg::addr_t        rd_cmd_addr,
	output vertex_pkg::array_sel_t   rd_cmd_array,
	output vertex_pkg::line_index_t  rd_cmd_count,
	output logic                     job_valid,
	output vertex_pkg::vertex_id_t   job_id,
	output vertex_pkg::vertex_word_t job_out_degree,
	output vertex_pkg::vertex_word_t job_edges_idx,
	output vertex_pkg::vertex_id_t   vertex_job_count,
	output vertex_pkg::vertex_id_t   filtered_count,
	output vertex_pkg::edge_count_t  edge_job_count,
	output logic                     busy
);

	import vertex_pkg::*;

	logic         load, block_advance, shift_step, lines_clear, push;
	logic         work_left, shift_last, lines_ready, room_for_line;
	line_index_t  line_count, shift_index;
	addr_t        block_offset;
	vertex_id_t   vertex_id;
	vertex_word_t out_degree_word, edges_idx_word;
	addr_t        out_degree_base_r, edges_idx_base_r;

	// Bases are latched when the sequencer accepts start
	always_ff @(posedge clock) begin
		if (load) begin
			out_degree_base_r <= out_degree_base;
			edges_idx_base_r  <= edges_idx_base;
		end
	end

	assign rd_cmd_addr  = ((rd_cmd_array == ARRAY_EDGES_IDX) ? edges_idx_base_r :
		out_degree_base_r) + block_offset;
	assign rd_cmd_count = line_count;

	vertex_fetch_fsm u_fetch_fsm (
		.clock, .rstn, .start, .work_left, .shift_last, .lines_ready, .room_for_line,
		.load, .block_advance, .shift_step, .lines_clear, .push,
		.rd_cmd_valid, .busy, .rd_cmd_array
	);

	vertex_block_counter u_block_counter (
		.clock, .rstn, .load, .block_advance, .shift_step, .num_vertices,
		.work_left, .shift_last, .line_count, .shift_index, .block_offset, .vertex_id
	);

	array_line_buffer u_line_buffer (
		.clock, .rstn, .rd_data_valid, .lines_clear, .rd_data_array, .rd_data_line,
		.shift_index, .lines_ready, .out_degree_word, .edges_idx_word
	);

	vertex_job_queue #(
		.JOB_DEPTH   (JOB_DEPTH),
		.JOB_CREDITS (JOB_CREDITS)
	) u_job_queue (
		.clock, .rstn, .push, .credit_return, .vertex_id, .out_degree_word, .edges_idx_word,
		.room_for_line, .job_valid, .job_id, .job_out_degree, .job_edges_idx,
		.vertex_job_count, .filtered_count, .edge_job_count
	);

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
// Clock and reset source for the vertex job controller testbench; instantiate once in the top
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen #(
	parameter int PERIOD       = 20,
	parameter int RESET_CYCLES = 3
) (
	output logic clock,
	output logic rstn
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	// Release a little after the edge, like the other stimulus
	initial begin
		rstn = 1'b0;
		repeat (RESET_CYCLES) @(posedge clock);
		#1;
		rstn = 1'b1;
	end

endmodule

`default_nettype wire

/* tb/vertex_job_control_tb.sv */
// Testbench for vertex_job_control; memory model, credit consumer, reference model and checker
`timescale 1ns/100ps
`default_nettype none

module vertex_job_control_tb;

	import vertex_pkg::*;

	localparam int JOB_DEPTH       = 16;
	localparam int JOB_CREDITS     = 4;
	localparam int DRIVE_DELAY     = 1;
	localparam int RUN1_N          = 21;
	localparam int RUN2_N          = 64;
	localparam int WITHHOLD_FILL   = 250;
	localparam int WITHHOLD_HOLD   = 150;
	localparam int WATCHDOG_CYCLES = 200 * (RUN1_N + RUN2_N) + 1000;

	logic         clock, rstn, start, rd_data_valid, credit_return;
	vertex_id_t   num_vertices;
	addr_t        out_degree_base, edges_idx_base, rd_cmd_addr;
	array_sel_t   rd_data_array, rd_cmd_array;
	line_t        rd_data_line;
	logic         rd_cmd_valid, job_valid, busy;
	line_index_t  rd_cmd_count;
	vertex_id_t   job_id, vertex_job_count, filtered_count;
	vertex_word_t job_out_degree, job_edges_idx;
	edge_count_t  edge_job_count;

	// Test data of the current run
	vertex_word_t deg_arr [64];
	vertex_word_t idx_arr [64];
	int           cur_n;
	addr_t        cur_ob, cur_eb;
	logic [31:0]  lcg_state = 32'd20143;

	// Expected jobs and commands, and reads not yet answered
	vertex_id_t   exp_id [$];
	vertex_word_t exp_deg [$];
	vertex_word_t exp_idx [$];
	addr_t        exp_cmd_addr [$];
	array_sel_t   exp_cmd_array [$];
	line_index_t  exp_cmd_count [$];
	addr_t        pend_addr [$];
	array_sel_t   pend_array [$];
	vertex_id_t   ref_jobs, ref_filtered;
	edge_count_t  ref_edges;
	int           tb_credits = JOB_CREDITS;
	bit           withhold, stall_window;

	tb_clock_gen #(.PERIOD(20), .RESET_CYCLES(3)) u_clock_gen (.clock, .rstn);

	vertex_job_control #(.JOB_DEPTH(JOB_DEPTH), .JOB_CREDITS(JOB_CREDITS)) UUT (.*);

	////////////////////////////////////////
	// Failure reporting and compares
	////////////////////////////////////////

	task automatic fail_run(input string what);
		$display("%s", what);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_job_id(input vertex_id_t got, input vertex_id_t exp, input string what);
		if (got !== exp)
			fail_run($sformatf("CHECK FAILED at %0t ns: %s is %0d, expected %0d",
				$time, what, got, exp));
	endtask

	task automatic check_vertex_word(input vertex_word_t got, input vertex_word_t exp,
		input string what);
		if (got !== exp)
			fail_run($sformatf("CHECK FAILED at %0t ns: %s is %0h, expected %0h",
				$time, what, got, exp));
	endtask

	task automatic check_addr(input addr_t got, input addr_t exp, input string what);
		if (got !== exp)
			fail_run($sformatf("CHECK FAILED at %0t ns: %s is %0h, expected %0h",
				$time, what, got, exp));
	endtask

	task automatic check_count(input line_index_t got, input line_index_t exp, input string what);
		if (got !== exp)
			fail_run($sformatf("CHECK FAILED at %0t ns: %s is %0d, expected %0d",
				$time, what, got, exp));
	endtask

	task automatic check_array(input array_sel_t got, input array_sel_t exp, input string what);
		if (got !== exp)
			fail_run($sformatf("CHECK FAILED at %0t ns: %s is %0d, expected %0d",
				$time, what, got, exp));
	endtask

	task automatic check_edges(input edge_count_t got, input edge_count_t exp, input string what);
		if (got !== exp)
			fail_run($sformatf("CHECK FAILED at %0t ns: %s is %0d, expected %0d",
				$time, what, got, exp));
	endtask

	////////////////////////////////////////
	// Data, reference model, memory lines
	////////////////////////////////////////

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return {16'h0000, lcg_state[30:15]};
	endfunction

	// About a quarter of the degrees are zero; edge index is the running sum
	task automatic gen_arrays(input int n);
		vertex_word_t sum;
		logic [31:0]  r;
		sum = '0;
		for (int i = 0; i < n; i++) begin
			r = next_rand();
			deg_arr[i] = (r[1:0] == 2'b00) ? '0 : vertex_word_t'(r[7:4]) + 1;
			idx_arr[i] = sum;
			sum = sum + deg_arr[i];
		end
	endtask

	function automatic void build_reference(input int n, input addr_t ob, input addr_t eb);
		int left;
		for (int b = 0; b * LINE_VERTICES < n; b++) begin
			left = n - b * LINE_VERTICES;
			exp_cmd_addr.push_back(ob + addr_t'(b * LINE_BYTES));
			exp_cmd_array.push_back(ARRAY_OUT_DEGREE);
			exp_cmd_addr.push_back(eb + addr_t'(b * LINE_BYTES));
			exp_cmd_array.push_back(ARRAY_EDGES_IDX);
			exp_cmd_count.push_back(line_index_t'((left < LINE_VERTICES) ? left : LINE_VERTICES));
			exp_cmd_count.push_back(line_index_t'((left < LINE_VERTICES) ? left : LINE_VERTICES));
		end
		for (int i = 0; i < n; i++) begin
			if (deg_arr[i] == '0) begin
				ref_filtered = ref_filtered + 1;
			end else begin
				exp_id.push_back(vertex_id_t'(i));
				exp_deg.push_back(deg_arr[i]);
				exp_idx.push_back(idx_arr[i]);
				ref_jobs  = ref_jobs + 1;
				ref_edges = ref_edges + edge_count_t'(deg_arr[i]);
			end
		end
	endfunction

	// Words past the vertex count carry a pattern of their own address
	function automatic line_t make_line(input addr_t addr, input array_sel_t arr);
		line_t data;
		addr_t w_addr;
		int    first;
		first = int'((addr - ((arr == ARRAY_OUT_DEGREE) ? cur_ob : cur_eb)) >> 2);
		for (int k = 0; k < LINE_VERTICES; k++) begin
			w_addr = addr + addr_t'(4 * k);
			if (first + k < cur_n)
				data[k*VERTEX_W +: VERTEX_W] = (arr == ARRAY_OUT_DEGREE) ?
					deg_arr[first+k] : idx_arr[first+k];
			else
				data[k*VERTEX_W +: VERTEX_W] = w_addr ^ 32'h5a5a_a5a5;
		end
		return data;
	endfunction

	////////////////////////////////////////
	// Memory model and consumer
	////////////////////////////////////////

	initial begin
		int sel;
		forever begin
			@(posedge clock);
			#DRIVE_DELAY;
			rd_data_valid = 1'b0;
			if (pend_addr.size() != 0 && next_rand() % 4 == 0) begin
				// Edge-index line may overtake the out-degree line
				sel = (pend_addr.size() > 1 && next_rand() % 2 == 1) ? 1 : 0;
				rd_data_array = pend_array[sel];
				rd_data_line  = make_line(pend_addr[sel], pend_array[sel]);
				rd_data_valid = 1'b1;
				pend_addr.delete(sel);
				pend_array.delete(sel);
			end
		end
	end

	initial begin
		forever begin
			@(posedge clock);
			#DRIVE_DELAY;
			credit_return = !withhold && (tb_credits < JOB_CREDITS) && (next_rand() % 3 == 0);
		end
	end

	////////////////////////////////////////
	// Comparing process at the falling edge
	////////////////////////////////////////

	always @(negedge clock) begin
		if (rstn) begin
			if (rd_cmd_valid) begin
				if (stall_window) begin
					fail_run("read command issued while the job FIFO had no room for a line");
				end else if (exp_cmd_addr.size() == 0) begin
					fail_run("read command issued that no block of the run needs");
				end else begin
					check_array(rd_cmd_array, exp_cmd_array.pop_front(), "rd_cmd_array");
					check_addr(rd_cmd_addr, exp_cmd_addr.pop_front(), "rd_cmd_addr");
					check_count(rd_cmd_count, exp_cmd_count.pop_front(), "rd_cmd_count");
					pend_addr.push_back(rd_cmd_addr);
					pend_array.push_back(rd_cmd_array);
				end
			end
			if (job_valid) begin
				if (tb_credits == 0) begin
					fail_run("job_valid high while the consumer held no credits");
				end else if (exp_id.size() == 0) begin
					fail_run("job issued beyond the expected job list");
				end else begin
					check_job_id(job_id, exp_id.pop_front(), "job_id");
					check_vertex_word(job_out_degree, exp_deg.pop_front(), "job_out_degree");
					check_vertex_word(job_edges_idx, exp_idx.pop_front(), "job_edges_idx");
				end
			end
			tb_credits = tb_credits - int'(job_valid) + int'(credit_return);
		end
	end

	////////////////////////////////////////
	// Runs
	////////////////////////////////////////

	task automatic run_job(input int n, input addr_t ob, input addr_t eb, input bit hold_credits);
		gen_arrays(n);
		cur_n  = n;
		cur_ob = ob;
		cur_eb = eb;
		build_reference(n, ob, eb);
		@(posedge clock);
		#DRIVE_DELAY;
		num_vertices    = vertex_id_t'(n);
		out_degree_base = ob;
		edges_idx_base  = eb;
		start           = 1'b1;
		withhold        = hold_credits;
		@(posedge clock);
		#DRIVE_DELAY;
		start = 1'b0;
		if (hold_credits) begin
			// Long enough for the credits to run out and the FIFO to fill
			repeat (WITHHOLD_FILL) @(posedge clock);
			stall_window = 1'b1;
			repeat (WITHHOLD_HOLD) @(posedge clock);
			@(negedge clock);
			if (!busy)
				fail_run("DUT finished the run although no credits were returned");
			stall_window = 1'b0;
			withhold     = 1'b0;
		end
		do @(negedge clock); while (busy || exp_id.size() != 0);
		// Totals update on the edge after the last job
		@(negedge clock);
		if (exp_cmd_addr.size() != 0)
			fail_run("DUT went idle before issuing every expected read command");
		check_job_id(vertex_job_count, ref_jobs, "vertex_job_count");
		check_job_id(filtered_count, ref_filtered, "filtered_count");
		check_edges(edge_job_count, ref_edges, "edge_job_count");
	endtask

	initial begin
		start           = 1'b0;
		num_vertices    = '0;
		out_degree_base = '0;
		edges_idx_base  = '0;
		rd_data_valid   = 1'b0;
		rd_data_array   = ARRAY_OUT_DEGREE;
		rd_data_line    = '0;
		credit_return   = 1'b0;
		withhold        = 1'b0;
		stall_window    = 1'b0;
		ref_jobs        = '0;
		ref_filtered    = '0;
		ref_edges       = '0;
		@(posedge rstn);
		@(negedge clock);
		if ({rd_cmd_valid, job_valid, busy} !== 3'b000)
			fail_run($sformatf("CHECK FAILED at %0t ns: outputs not idle after reset", $time));
		check_job_id(vertex_job_count, '0, "vertex_job_count after reset");
		check_job_id(filtered_count, '0, "filtered_count after reset");
		check_edges(edge_job_count, '0, "edge_job_count after reset");
		run_job(RUN1_N, 32'h1000_0000, 32'h2000_0400, 1'b0);
		// Second start with long credit starvation
		run_job(RUN2_N, 32'h3000_0100, 32'h4800_0000, 1'b1);
		$display("TEST PASSED");
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		fail_run($sformatf("watchdog expired after %0d cycles, the DUT stopped making progress",
			WATCHDOG_CYCLES));
	end

endmodule

`default_nettype wire

/* build.f */
src/vertex_pkg.sv
src/vertex_fetch_fsm.sv
src/vertex_block_counter.sv
src/array_line_buffer.sv
src/vertex_job_queue.sv
src/vertex_job_control.sv
tb/tb_clock_gen.sv
tb/vertex_job_control_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module vertex_job_control_tb \
	-f build.f -Mdir obj_dir -o sim_vertex_job_control

./obj_dir/sim_vertex_job_control > sim.log 2>&1 || true
cat sim.log

grep -qx "TEST PASSED" sim.log
